//--- design/game_pkg.sv
package game_pkg;

    localparam int num_digits = 4;
    localparam logic [2:0] win_bulls = 3'd4;

    // xnor feedback, so the all-zero state is a legal start
    localparam logic [15:0] lfsr_seed = 16'h0000;

    typedef logic [3:0] digit_t;

    // d3 is the leftmost digit on the display
    typedef struct packed {
        digit_t d3;
        digit_t d2;
        digit_t d1;
        digit_t d0;
    } guess_t;

    typedef struct packed {
        logic [2:0] a; // right digit, right place
        logic [2:0] b; // right digit, wrong place
    } score_t;

    // entry phases are consecutive, the controller steps through them by +1
    typedef enum logic [2:0] {
        idle   = 3'd0,
        entry0 = 3'd1,
        entry1 = 3'd2,
        entry2 = 3'd3,
        entry3 = 3'd4,
        result = 3'd5
    } phase_e;

endpackage

//--- design/display_pkg.sv
package display_pkg;

    localparam int scan_period    = 16;  // cycles per digit position
    localparam int flicker_period = 128; // cycles per flicker half period

    typedef logic [6:0] seg_t; // active low, segment a in bit 6

    localparam seg_t seg_0     = 7'b0000001;
    localparam seg_t seg_1     = 7'b1001111;
    localparam seg_t seg_2     = 7'b0010010;
    localparam seg_t seg_3     = 7'b0000110;
    localparam seg_t seg_4     = 7'b1001100;
    localparam seg_t seg_5     = 7'b0100100;
    localparam seg_t seg_6     = 7'b0100000;
    localparam seg_t seg_7     = 7'b0001111;
    localparam seg_t seg_8     = 7'b0000000;
    localparam seg_t seg_9     = 7'b0000100;
    localparam seg_t seg_a     = 7'b0001000;
    localparam seg_t seg_b     = 7'b1100000;
    localparam seg_t seg_blank = 7'b1111111;

    // digit glyphs keep their numeric value so a digit casts straight in
    typedef enum logic [3:0] {
        g0, g1, g2, g3, g4, g5, g6, g7, g8, g9,
        g_a,
        g_b,
        g_blank
    } glyph_e;

    typedef struct packed {
        glyph_e p3; // leftmost
        glyph_e p2;
        glyph_e p1;
        glyph_e p0;
    } disp_frame_t;

endpackage

//--- design/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic pulse
);

    localparam int db_len = 4;

    logic [db_len-1:0] sync_sr;
    logic              stable;
    logic              stable_d;

    assign stable = &sync_sr; // high only after db_len samples in a row

    always_ff @(posedge clk) begin
        if (!rst) begin
            sync_sr  <= '0;
            stable_d <= 1'b0;
            pulse    <= 1'b0;
        end else begin
            sync_sr  <= {sync_sr[db_len-2:0], btn};
            stable_d <= stable;
            pulse    <= stable & ~stable_d; // rising edge of the stable level
        end
    end

endmodule

//--- design/secret_generator.sv
`timescale 1ns/1ps

module secret_generator (
    input  logic            clk,
    input  logic            rst,
    output game_pkg::guess_t candidate
);

    logic [15:0]      lfsr;
    logic             feedback;
    game_pkg::digit_t r3, r2, r1, r0; // raw nibbles folded to 0..9
    game_pkg::digit_t v3, v2, v1, v0; // repaired, all distinct

    function automatic game_pkg::digit_t inc10(input game_pkg::digit_t d);
        return (d == 4'd9) ? 4'd0 : d + 4'd1;
    endfunction

    function automatic logic is_free(input game_pkg::digit_t d,
                                     input game_pkg::digit_t x,
                                     input game_pkg::digit_t y,
                                     input game_pkg::digit_t z);
        return (d != x) && (d != y) && (d != z);
    endfunction

    assign feedback = ~(lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]);

    always_ff @(posedge clk) begin
        if (!rst) begin
            lfsr <= game_pkg::lfsr_seed;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    assign r3 = lfsr[15:12] % 4'd10;
    assign r2 = lfsr[11:8] % 4'd10;
    assign r1 = lfsr[7:4] % 4'd10;
    assign r0 = lfsr[3:0] % 4'd10;

    always_comb begin
        v3 = r3;
        v2 = (r2 == v3) ? inc10(v3) : r2;

        // two bumps at most, since only v2 and v3 are taken
        v1 = r1;
        if (v1 == v2 || v1 == v3) v1 = inc10(v1);
        if (v1 == v2 || v1 == v3) v1 = inc10(v1);

        // fixed fill order for the last digit
        if (is_free(r0, v1, v2, v3))          v0 = r0;
        else if (is_free(4'd4, v1, v2, v3))   v0 = 4'd4;
        else if (is_free(4'd2, v1, v2, v3))   v0 = 4'd2;
        else if (is_free(4'd8, v1, v2, v3))   v0 = 4'd8;
        else if (is_free(4'd9, v1, v2, v3))   v0 = 4'd9;
        else if (is_free(4'd1, v1, v2, v3))   v0 = 4'd1;
        else if (is_free(4'd6, v1, v2, v3))   v0 = 4'd6;
        else if (is_free(4'd3, v1, v2, v3))   v0 = 4'd3;
        else if (is_free(4'd7, v1, v2, v3))   v0 = 4'd7;
        else if (is_free(4'd5, v1, v2, v3))   v0 = 4'd5;
        else                                  v0 = 4'd0;
    end

    assign candidate = '{d3: v3, d2: v2, d1: v1, d0: v0};

endmodule

//--- design/guess_scorer.sv
`timescale 1ns/1ps

module guess_scorer (
    input  game_pkg::guess_t secret,
    input  game_pkg::guess_t guess,
    output game_pkg::score_t score
);

    always_comb begin
        game_pkg::digit_t s [game_pkg::num_digits];
        game_pkg::digit_t g [game_pkg::num_digits];
        logic [2:0]       a_cnt;
        logic [2:0]       b_cnt;
        logic             hit;

        s = '{secret.d0, secret.d1, secret.d2, secret.d3};
        g = '{guess.d0, guess.d1, guess.d2, guess.d3};
        a_cnt = 3'd0;
        b_cnt = 3'd0;
        for (int i = 0; i < game_pkg::num_digits; i++) begin
            if (s[i] == g[i]) a_cnt = a_cnt + 3'd1;
            hit = 1'b0;
            for (int j = 0; j < game_pkg::num_digits; j++) begin
                if (j != i && s[i] == g[j]) hit = 1'b1; // same digit elsewhere
            end
            if (hit) b_cnt = b_cnt + 3'd1;
        end
        score.a = a_cnt;
        score.b = b_cnt;
    end

endmodule

//--- design/game_controller.sv
`timescale 1ns/1ps

module game_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_pulse,
    input  logic                     enter_pulse,
    input  game_pkg::digit_t         num,
    input  game_pkg::guess_t         candidate,
    input  game_pkg::score_t         score,
    output game_pkg::guess_t         secret,
    output game_pkg::guess_t         guess,
    output display_pkg::disp_frame_t frame
);

    game_pkg::phase_e phase;
    game_pkg::score_t score_q;
    logic             flicker;
    logic [$clog2(display_pkg::flicker_period)-1:0] flick_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase   <= game_pkg::idle;
            secret  <= '0;
            guess   <= '0;
            score_q <= '0;
        end else begin
            case (phase)
                game_pkg::idle: begin
                    if (start_pulse) begin
                        secret <= candidate;
                        guess  <= '0;
                        phase  <= game_pkg::entry0;
                    end
                end
                game_pkg::entry0, game_pkg::entry1,
                game_pkg::entry2, game_pkg::entry3: begin
                    if (enter_pulse) begin
                        guess <= '{d3: guess.d2, d2: guess.d1, d1: guess.d0, d0: num};
                        phase <= game_pkg::phase_e'(phase + 3'd1); // entry3 steps to result
                    end
                end
                game_pkg::result: begin
                    score_q <= score; // guess is stable here, lands one cycle in
                    if (enter_pulse) begin
                        if (score.a == game_pkg::win_bulls) begin
                            secret <= '0;
                            phase  <= game_pkg::idle;
                        end else begin
                            guess <= '0;
                            phase <= game_pkg::entry0;
                        end
                    end
                end
                default: phase <= game_pkg::idle;
            endcase
        end
    end

    // flicker for the digit being entered
    always_ff @(posedge clk) begin
        if (!rst) begin
            flick_cnt <= '0;
            flicker   <= 1'b0;
        end else if (flick_cnt == display_pkg::flicker_period - 1) begin
            flick_cnt <= '0;
            flicker   <= ~flicker;
        end else begin
            flick_cnt <= flick_cnt + 1'b1;
        end
    end

    always_comb begin
        case (phase)
            game_pkg::idle: begin
                frame = '{p3: display_pkg::g1, p2: display_pkg::g_a,
                          p1: display_pkg::g2, p0: display_pkg::g_b};
            end
            game_pkg::result: begin
                frame.p3 = display_pkg::glyph_e'({1'b0, score_q.a});
                frame.p2 = display_pkg::g_a;
                frame.p1 = display_pkg::glyph_e'({1'b0, score_q.b});
                frame.p0 = display_pkg::g_b;
            end
            default: begin
                frame.p3 = display_pkg::glyph_e'(guess.d2);
                frame.p2 = display_pkg::glyph_e'(guess.d1);
                frame.p1 = display_pkg::glyph_e'(guess.d0);
                frame.p0 = flicker ? display_pkg::g_blank : display_pkg::glyph_e'(num);
            end
        endcase
    end

endmodule

//--- design/display_scanner.sv
`timescale 1ns/1ps

module display_scanner (
    input  logic                     clk,
    input  logic                     rst,
    input  display_pkg::disp_frame_t frame,
    output logic [3:0]               an,
    output display_pkg::seg_t        seg
);

    logic [$clog2(display_pkg::scan_period)-1:0] step_cnt;
    logic [1:0]          pos;
    display_pkg::glyph_e glyph;
    display_pkg::seg_t   pattern;

    always_comb begin
        case (pos)
            2'd0:    glyph = frame.p0;
            2'd1:    glyph = frame.p1;
            2'd2:    glyph = frame.p2;
            default: glyph = frame.p3;
        endcase
    end

    always_comb begin
        case (glyph)
            display_pkg::g0:  pattern = display_pkg::seg_0;
            display_pkg::g1:  pattern = display_pkg::seg_1;
            display_pkg::g2:  pattern = display_pkg::seg_2;
            display_pkg::g3:  pattern = display_pkg::seg_3;
            display_pkg::g4:  pattern = display_pkg::seg_4;
            display_pkg::g5:  pattern = display_pkg::seg_5;
            display_pkg::g6:  pattern = display_pkg::seg_6;
            display_pkg::g7:  pattern = display_pkg::seg_7;
            display_pkg::g8:  pattern = display_pkg::seg_8;
            display_pkg::g9:  pattern = display_pkg::seg_9;
            display_pkg::g_a: pattern = display_pkg::seg_a;
            display_pkg::g_b: pattern = display_pkg::seg_b;
            default:          pattern = display_pkg::seg_blank; // blank and bad switch values
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            step_cnt <= '0;
            pos      <= 2'd0;
            an       <= 4'b1111; // all digits dark until the first step
            seg      <= display_pkg::seg_blank;
        end else if (step_cnt == display_pkg::scan_period - 1) begin
            step_cnt <= '0;
            pos      <= pos + 2'd1;
            an       <= ~(4'b0001 << pos);
            seg      <= pattern;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

//--- design/bulls_cows_top.sv
`timescale 1ns/1ps

module bulls_cows_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_btn,
    input  logic              enter_btn,
    input  game_pkg::digit_t  num,
    output logic [3:0]        an,
    output display_pkg::seg_t seg,
    output game_pkg::guess_t  secret // shown on the leds
);

    logic                     start_pulse;
    logic                     enter_pulse;
    game_pkg::guess_t         candidate;
    game_pkg::guess_t         guess;
    game_pkg::score_t         score;
    display_pkg::disp_frame_t frame;

    button_conditioner u_start_btn (
        .clk   (clk),
        .rst   (rst),
        .btn   (start_btn),
        .pulse (start_pulse)
    );

    button_conditioner u_enter_btn (
        .clk   (clk),
        .rst   (rst),
        .btn   (enter_btn),
        .pulse (enter_pulse)
    );

    secret_generator u_secret_gen (
        .clk       (clk),
        .rst       (rst),
        .candidate (candidate)
    );

    guess_scorer u_scorer (
        .secret (secret),
        .guess  (guess),
        .score  (score)
    );

    game_controller u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .enter_pulse (enter_pulse),
        .num         (num),
        .candidate   (candidate),
        .score       (score),
        .secret      (secret),
        .guess       (guess),
        .frame       (frame)
    );

    display_scanner u_scanner (
        .clk   (clk),
        .rst   (rst),
        .frame (frame),
        .an    (an),
        .seg   (seg)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam realtime half_period = 5ns; // 10 ns clock
    localparam int      reset_cycles = 2;

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    initial begin
        rst = 1'b0; // active low, held for reset_cycles rising edges
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- test/bulls_cows_tb.sv
`timescale 1ns/1ps

module bulls_cows_tb;

    localparam logic [31:0] seed        = 32'h0c75_10fe;
    localparam int num_games            = 5;
    localparam int num_guesses          = 20;
    localparam int press_hold           = 8;
    localparam int num_presses          = num_games * 6 + 1 + num_guesses * 5 + 10;
    localparam int watchdog_cycles      = 2000 * num_presses + 20000;
    localparam display_pkg::disp_frame_t idle_frame =
        '{p3: display_pkg::g1, p2: display_pkg::g_a, p1: display_pkg::g2, p0: display_pkg::g_b};

    logic                     clk, rst, start_btn, enter_btn;
    game_pkg::digit_t         num;
    logic [3:0]               an;
    display_pkg::seg_t        seg;
    game_pkg::guess_t         secret;

    logic [31:0]              rng;
    game_pkg::guess_t         cur_secret;
    game_pkg::guess_t         exp_guess; // guess as the shift rule predicts it
    logic                     in_game;
    int                       non_wins = 0;
    game_pkg::score_t         exp_score_q [$];
    display_pkg::disp_frame_t got_result_q [$];

    tb_clock u_clock (.clk(clk), .rst(rst));

    bulls_cows_top UUT (
        .clk       (clk),
        .rst       (rst),
        .start_btn (start_btn),
        .enter_btn (enter_btn),
        .num       (num),
        .an        (an),
        .seg       (seg),
        .secret    (secret)
    );

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    task automatic check_guess(input string name, input game_pkg::guess_t exp,
                               input game_pkg::guess_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_frame(input string name, input display_pkg::disp_frame_t exp,
                               input display_pkg::disp_frame_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_score(input string name, input game_pkg::score_t exp,
                               input game_pkg::score_t act);
        if (act !== exp) begin
            $display("Error %s: expected %0dA%0dB, actual %0dA%0dB", name, exp.a, exp.b,
                     act.a, act.b);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bulls and cows by the counting rule for distinct digits
    function automatic game_pkg::score_t score_ref(input game_pkg::guess_t s,
                                                   input game_pkg::guess_t g);
        game_pkg::digit_t sd [4];
        game_pkg::digit_t gd [4];
        game_pkg::score_t r;
        sd = '{s.d3, s.d2, s.d1, s.d0};
        gd = '{g.d3, g.d2, g.d1, g.d0};
        r = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (sd[i] == gd[j] && i == j) r.a = r.a + 3'd1;
                else if (sd[i] == gd[j]) r.b = r.b + 3'd1;
            end
        end
        return r;
    endfunction

    function automatic display_pkg::glyph_e seg_to_glyph(input display_pkg::seg_t s);
        case (s)
            display_pkg::seg_0: return display_pkg::g0;
            display_pkg::seg_1: return display_pkg::g1;
            display_pkg::seg_2: return display_pkg::g2;
            display_pkg::seg_3: return display_pkg::g3;
            display_pkg::seg_4: return display_pkg::g4;
            display_pkg::seg_5: return display_pkg::g5;
            display_pkg::seg_6: return display_pkg::g6;
            display_pkg::seg_7: return display_pkg::g7;
            display_pkg::seg_8: return display_pkg::g8;
            display_pkg::seg_9: return display_pkg::g9;
            display_pkg::seg_a: return display_pkg::g_a;
            display_pkg::seg_b: return display_pkg::g_b;
            default:            return display_pkg::g_blank;
        endcase
    endfunction

    // collects four fresh scan steps into one frame
    task automatic read_display(output display_pkg::disp_frame_t f);
        logic [3:0]          seen;
        logic [3:0]          last_an;
        int                  waited;
        display_pkg::glyph_e gl;
        seen = 4'b0000;
        waited = 0;
        f = idle_frame;
        @(negedge clk);
        last_an = an;
        while (seen != 4'b1111) begin
            @(negedge clk);
            waited++;
            if (waited > (game_pkg::num_digits + 1) * display_pkg::scan_period + 2)
                report_failure("display did not scan all four positions in time");
            if (an != last_an) begin
                last_an = an;
                gl = seg_to_glyph(seg);
                if (gl == display_pkg::g_blank && seg !== display_pkg::seg_blank)
                    report_failure($sformatf("unknown segment pattern %b", seg));
                case (an)
                    4'b1110: begin
                        f.p0 = gl;
                        seen[0] = 1'b1;
                    end
                    4'b1101: begin
                        f.p1 = gl;
                        seen[1] = 1'b1;
                    end
                    4'b1011: begin
                        f.p2 = gl;
                        seen[2] = 1'b1;
                    end
                    4'b0111: begin
                        f.p3 = gl;
                        seen[3] = 1'b1;
                    end
                    default: report_failure($sformatf("anode pattern %b is not one-hot", an));
                endcase
            end
        end
    endtask

    task automatic press_button(input logic use_start);
        @(posedge clk);
        if (use_start) start_btn <= 1'b1;
        else enter_btn <= 1'b1;
        repeat (press_hold) @(posedge clk);
        start_btn <= 1'b0;
        enter_btn <= 1'b0;
        repeat (press_hold) @(posedge clk);
    endtask

    task automatic enter_digit(input game_pkg::digit_t d);
        @(posedge clk);
        num <= d;
        press_button(1'b0);
        exp_guess = '{d3: exp_guess.d2, d2: exp_guess.d1, d1: exp_guess.d0, d0: d};
    endtask

    task automatic check_entry_frame(input string name);
        display_pkg::disp_frame_t f;
        display_pkg::disp_frame_t exp_f;
        read_display(f);
        // p0 may show the switch digit or blank while it flickers
        if (f.p0 == display_pkg::glyph_e'(num) || f.p0 == display_pkg::g_blank)
            f.p0 = display_pkg::g_blank;
        exp_f = '{p3: display_pkg::glyph_e'(exp_guess.d2),
                  p2: display_pkg::glyph_e'(exp_guess.d1),
                  p1: display_pkg::glyph_e'(exp_guess.d0),
                  p0: display_pkg::g_blank};
        check_frame(name, exp_f, f);
    endtask

    task automatic check_flicker();
        logic seen_digit;
        logic seen_blank;
        seen_digit = 1'b0;
        seen_blank = 1'b0;
        repeat (2 * display_pkg::flicker_period + 4 * display_pkg::scan_period) begin
            @(negedge clk);
            if (an == 4'b1110 && seg_to_glyph(seg) == display_pkg::glyph_e'(num))
                seen_digit = 1'b1;
            if (an == 4'b1110 && seg == display_pkg::seg_blank) seen_blank = 1'b1;
        end
        if (!(seen_digit && seen_blank))
            report_failure("entry digit did not alternate between switch value and blank");
    endtask

    task automatic check_secret_digits(input game_pkg::guess_t s);
        game_pkg::digit_t d [4];
        d = '{s.d3, s.d2, s.d1, s.d0};
        for (int i = 0; i < 4; i++) begin
            if (d[i] > 4'd9) report_failure($sformatf("secret %h holds a digit above 9", s));
            for (int j = i + 1; j < 4; j++) begin
                if (d[i] == d[j]) report_failure($sformatf("secret %h repeats a digit", s));
            end
        end
    endtask

    task automatic start_game();
        press_button(1'b1);
        @(negedge clk);
        cur_secret = secret; // read back from the led port
        check_secret_digits(cur_secret);
        exp_guess = '0;
        in_game = 1'b1;
        check_entry_frame("after start");
    endtask

    task automatic random_guess(output game_pkg::guess_t g);
        logic [9:0]       used;
        game_pkg::digit_t d;
        used = '0;
        g = '0;
        for (int i = 0; i < 4; i++) begin
            do begin
                rng = xorshift32(rng);
                d = game_pkg::digit_t'(rng % 10);
            end while (used[d]);
            used[d] = 1'b1;
            g = {g[11:0], d};
        end
    endtask

    task automatic enter_guess(input game_pkg::guess_t g, input logic check_entry,
                               input logic check_flick);
        game_pkg::digit_t ds [4];
        ds = '{g.d3, g.d2, g.d1, g.d0};
        for (int i = 0; i < 4; i++) begin
            enter_digit(ds[i]);
            if (check_entry && i < 3) check_entry_frame($sformatf("entry %0d", i + 1));
            if (check_flick && i == 2) check_flicker();
        end
    endtask

    task automatic finish_guess(input string name);
        display_pkg::disp_frame_t f;
        game_pkg::score_t         exp_s;
        exp_s = score_ref(cur_secret, exp_guess);
        read_display(f);
        exp_score_q.push_back(exp_s);
        got_result_q.push_back(f);
        press_button(1'b0);
        if (exp_s.a == game_pkg::win_bulls) begin
            read_display(f);
            check_frame({name, " back to idle"}, idle_frame, f);
            check_guess({name, " secret cleared"}, '0, secret);
            in_game = 1'b0;
        end else begin
            exp_guess = '0;
            check_entry_frame({name, " new guess"});
            check_guess({name, " secret kept"}, cur_secret, secret);
            non_wins++;
        end
    endtask

    always @(negedge clk) begin : compare_results
        game_pkg::score_t         exp_s;
        game_pkg::score_t         got_s;
        display_pkg::disp_frame_t got_f;
        display_pkg::disp_frame_t exp_f;
        if (got_result_q.size() > 0) begin
            exp_s = exp_score_q.pop_front();
            got_f = got_result_q.pop_front();
            got_s.a = 3'(got_f.p3);
            got_s.b = 3'(got_f.p1);
            exp_f = '{p3: display_pkg::glyph_e'({1'b0, exp_s.a}), p2: display_pkg::g_a,
                      p1: display_pkg::glyph_e'({1'b0, exp_s.b}), p0: display_pkg::g_b};
            check_score("result score", exp_s, got_s);
            check_frame("result frame", exp_f, got_f);
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        report_failure($sformatf("timeout, run did not finish in %0d cycles", watchdog_cycles));
    end

    initial begin : stimulus
        game_pkg::guess_t         drawn [num_games];
        game_pkg::guess_t         g;
        display_pkg::disp_frame_t f;
        logic                     differ;
        start_btn = 1'b0;
        enter_btn = 1'b0;
        num = '0;
        rng = seed;
        in_game = 1'b0;
        wait (rst === 1'b1);
        @(negedge clk);
        check_bit("reset an", 4'b1111, an);
        check_guess("reset secret", '0, secret);
        read_display(f);
        check_frame("idle banner", idle_frame, f);

        // each draw is won at once by typing the secret back in
        for (int k = 0; k < num_games; k++) begin
            start_game();
            drawn[k] = cur_secret;
            enter_guess(cur_secret, 1'b1, k == 0);
            finish_guess("win");
        end
        differ = 1'b0;
        for (int k = 1; k < num_games; k++) begin
            if (drawn[k] != drawn[0]) differ = 1'b1;
        end
        if (!differ) report_failure("all drawn secrets were the same");

        for (int n = 0; n < num_guesses; n++) begin
            if (!in_game) start_game();
            random_guess(g);
            enter_guess(g, 1'b0, 1'b0);
            finish_guess($sformatf("guess %0d", n));
        end

        wait (got_result_q.size() == 0);
        @(negedge clk);
        if (non_wins > 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure("no random guess ended below four bulls");
        end
    end

endmodule

//--- sim.f
design/game_pkg.sv
design/display_pkg.sv
design/button_conditioner.sv
design/secret_generator.sv
design/guess_scorer.sv
design/game_controller.sv
design/display_scanner.sv
design/bulls_cows_top.sv
test/tb_clock.sv
test/bulls_cows_tb.sv
